//--- core_region.f
source/core_region_pkg.sv
source/sp_ram.sv
source/ram_mux.sv
source/lsu_demux.sv
source/core_region.sv
bench/tb_core_region.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_core_region \
	  -f core_region.f -o sim_core_region
	./obj_dir/sim_core_region | awk '{ print } /\*\* PASS \*\*/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- bench/tb_core_region.sv
module tb_core_region;
  timeunit 1ns;
  timeprecision 1ps;
  import core_region_pkg::*;

  // tests need under 500 cycles
  localparam int CYCLE_LIMIT = 4 * 500;
  localparam int N_WORDS     = 16;

  logic        clk, rst_n;
  logic        instr_req_i, instr_gnt_o, instr_rvalid_o;
  logic        lsu_req_i, lsu_gnt_o, lsu_rvalid_o;
  logic        iload_req_i, dload_req_i;
  logic        ext_req_o, ext_gnt_i, ext_rvalid_i;
  mem_req_t    instr_cmd_i, lsu_cmd_i, ext_cmd_o;
  loader_req_t iload_cmd_i, dload_cmd_i;
  word_t       instr_rdata_o, lsu_rdata_o, iload_rdata_o, dload_rdata_o, ext_rdata_i;

  // reference contents of both RAMs
  word_t       imem_ref [0:2**INSTR_ADDR_W-1];
  word_t       dmem_ref [0:2**DATA_ADDR_W-1];
  integer      seed = 32'he371_b061;
  int          cycles = 0;

  core_region UUT (.*);

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout, a handshake never completed within %0d cycles", cycles);
      abort_run();
    end
  end

  task automatic abort_run;
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
    begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cmd(input string name, input mem_req_t exp, input mem_req_t act);
    if (act !== exp)
    begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic expect_rvalid(input string port, input logic rvalid);
    if (rvalid !== 1'b1)
    begin
      $display("no rvalid on the %s port when the response was due", port);
      abort_run();
    end
  endtask

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
    word_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // data RAM region tag
  function automatic word_t local_addr(input int idx);
    return {12'h001, 20'(idx * 4)};
  endfunction

  // one loader cycle, read data due one cycle later
  task automatic loader_access(input logic instr_side, input loader_req_t cmd);
    int idx;
    idx = int'(cmd.addr);
    @(negedge clk);
    iload_req_i = instr_side;
    iload_cmd_i = cmd;
    dload_req_i = !instr_side;
    dload_cmd_i = cmd;
    @(negedge clk);
    if (cmd.we && instr_side)
      imem_ref[idx] = merge_bytes(imem_ref[idx], cmd.wdata, cmd.be);
    else if (cmd.we)
      dmem_ref[idx] = merge_bytes(dmem_ref[idx], cmd.wdata, cmd.be);
    else if (instr_side)
      check_word("iload_rdata_o", imem_ref[idx], iload_rdata_o);
    else
      check_word("dload_rdata_o", dmem_ref[idx], dload_rdata_o);
    iload_req_i = 1'b0;
    dload_req_i = 1'b0;
  endtask

  task automatic fetch_word(input int idx, input logic we);
    @(negedge clk);
    instr_req_i = 1'b1;
    instr_cmd_i = '{addr: word_t'(idx * 4), we: we, be: 4'hf, wdata: word_t'($random(seed))};
    #1;
    while (instr_gnt_o !== 1'b1)
    begin
      @(negedge clk);
      #1;
    end
    check_bit("instr_rvalid_o", 1'b0, instr_rvalid_o);
    @(negedge clk);
    expect_rvalid("fetch", instr_rvalid_o);
    check_word("instr_rdata_o", imem_ref[idx], instr_rdata_o);
    instr_req_i = 1'b0;
  endtask

  task automatic lsu_write(input int idx, input be_t be, input word_t wdata);
    @(negedge clk);
    lsu_req_i = 1'b1;
    lsu_cmd_i = '{addr: local_addr(idx), we: 1'b1, be: be, wdata: wdata};
    #1;
    while (lsu_gnt_o !== 1'b1)
    begin
      @(negedge clk);
      #1;
    end
    check_bit("ext_req_o", 1'b0, ext_req_o);
    @(negedge clk);
    expect_rvalid("load/store", lsu_rvalid_o);
    dmem_ref[idx] = merge_bytes(dmem_ref[idx], wdata, be);
    check_word("lsu_rdata_o", '0, lsu_rdata_o);
    lsu_req_i = 1'b0;
  endtask

  task automatic ext_access(input word_t addr, input logic we, input int gnt_wait,
                            input int rsp_wait);
    mem_req_t cmd;
    word_t    rsp;
    cmd = '{addr: addr, we: we, be: 4'hf, wdata: word_t'($random(seed))};
    rsp = word_t'($random(seed));
    @(negedge clk);
    lsu_req_i = 1'b1;
    lsu_cmd_i = cmd;
    // bus holds off its grant
    repeat (gnt_wait)
    begin
      #1;
      check_bit("ext_req_o", 1'b1, ext_req_o);
      check_cmd("ext_cmd_o", cmd, ext_cmd_o);
      check_bit("lsu_gnt_o", 1'b0, lsu_gnt_o);
      @(negedge clk);
    end
    ext_gnt_i = 1'b1;
    #1;
    check_bit("lsu_gnt_o", 1'b1, lsu_gnt_o);
    @(negedge clk);
    lsu_req_i = 1'b0;
    ext_gnt_i = 1'b0;
    repeat (rsp_wait)
    begin
      check_bit("lsu_rvalid_o", 1'b0, lsu_rvalid_o);
      @(negedge clk);
    end
    ext_rvalid_i = 1'b1;
    ext_rdata_i  = rsp;
    #1;
    expect_rvalid("load/store", lsu_rvalid_o);
    check_word("lsu_rdata_o", rsp, lsu_rdata_o);
    @(negedge clk);
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
  endtask

  task automatic reset_values;
    // requests held in reset must get no response
    instr_req_i = 1'b1;
    lsu_req_i   = 1'b1;
    lsu_cmd_i   = '{addr: local_addr(0), we: 1'b0, be: 4'hf, wdata: '0};
    repeat (5) @(negedge clk);
    check_bit("instr_rvalid_o", 1'b0, instr_rvalid_o);
    check_bit("lsu_rvalid_o", 1'b0, lsu_rvalid_o);
    check_bit("ext_req_o", 1'b0, ext_req_o);
    instr_req_i = 1'b0;
    lsu_req_i   = 1'b0;
    rst_n       = 1'b1;
    @(negedge clk);
    check_bit("instr_rvalid_o", 1'b0, instr_rvalid_o);
    check_bit("lsu_rvalid_o", 1'b0, lsu_rvalid_o);
    check_bit("ext_req_o", 1'b0, ext_req_o);
  endtask

  task automatic loader_fill_and_read;
    loader_req_t cmd;
    for (int side = 1; side >= 0; side--)
    begin
      // full words first so no byte stays unknown
      for (int i = 0; i < N_WORDS; i++)
      begin
        cmd = '{addr: word_idx_t'(i), we: 1'b1, be: 4'hf, wdata: word_t'($random(seed))};
        loader_access(side == 1, cmd);
      end
      for (int i = 0; i < N_WORDS; i += 2)
      begin
        cmd = '{addr: word_idx_t'(i), we: 1'b1, be: be_t'($random(seed)),
                wdata: word_t'($random(seed))};
        loader_access(side == 1, cmd);
      end
      for (int i = 0; i < N_WORDS; i++)
      begin
        cmd = '{addr: word_idx_t'(i), we: 1'b0, be: 4'h0, wdata: '0};
        loader_access(side == 1, cmd);
      end
    end
  endtask

  task automatic fetch_sequence;
    loader_req_t cmd;
    for (int i = 0; i < N_WORDS; i++)
      fetch_word(i, 1'b0);
    // a store on the fetch port must not land
    fetch_word(3, 1'b1);
    cmd = '{addr: word_idx_t'(3), we: 1'b0, be: 4'h0, wdata: '0};
    loader_access(1'b1, cmd);
  endtask

  task automatic local_data_traffic;
    for (int i = 0; i < N_WORDS; i++)
      lsu_write(i, be_t'($random(seed)), word_t'($random(seed)));
    // back-to-back reads, one rvalid per cycle
    @(negedge clk);
    for (int i = 0; i < N_WORDS; i++)
    begin
      lsu_req_i = 1'b1;
      lsu_cmd_i = '{addr: local_addr(i), we: 1'b0, be: 4'hf, wdata: '0};
      #1;
      check_bit("lsu_gnt_o", 1'b1, lsu_gnt_o);
      @(negedge clk);
      expect_rvalid("load/store", lsu_rvalid_o);
      check_word("lsu_rdata_o", dmem_ref[i], lsu_rdata_o);
    end
    lsu_req_i = 1'b0;
    // loader and core hit the data RAM together
    @(negedge clk);
    dload_req_i = 1'b1;
    dload_cmd_i = '{addr: word_idx_t'(5), we: 1'b0, be: 4'h0, wdata: '0};
    lsu_req_i   = 1'b1;
    lsu_cmd_i   = '{addr: local_addr(9), we: 1'b0, be: 4'hf, wdata: '0};
    #1;
    check_bit("lsu_gnt_o", 1'b0, lsu_gnt_o);
    @(negedge clk);
    check_word("dload_rdata_o", dmem_ref[5], dload_rdata_o);
    check_bit("lsu_rvalid_o", 1'b0, lsu_rvalid_o);
    dload_req_i = 1'b0;
    #1;
    check_bit("lsu_gnt_o", 1'b1, lsu_gnt_o);
    @(negedge clk);
    expect_rvalid("load/store", lsu_rvalid_o);
    check_word("lsu_rdata_o", dmem_ref[9], lsu_rdata_o);
    lsu_req_i = 1'b0;
  endtask

  task automatic external_traffic;
    loader_req_t cmd;
    for (int i = 0; i < 4; i++)
    begin
      // tags 0x000 to 0x006 miss the local region
      ext_access({12'(i * 2), 20'(i * 4)}, i[0], i + 1, $random(seed) & 3);
      cmd = '{addr: word_idx_t'(i), we: 1'b0, be: 4'h0, wdata: '0};
      loader_access(1'b0, cmd);
    end
  endtask

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    instr_req_i  = 1'b0;
    instr_cmd_i  = '0;
    lsu_req_i    = 1'b0;
    lsu_cmd_i    = '0;
    iload_req_i  = 1'b0;
    iload_cmd_i  = '0;
    dload_req_i  = 1'b0;
    dload_cmd_i  = '0;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    reset_values();
    loader_fill_and_read();
    fetch_sequence();
    local_data_traffic();
    external_traffic();
    @(negedge clk);
    $display("** PASS **");
    $finish;
  end

endmodule

//--- source/core_region.sv
module core_region
(
  input  logic                         clk,
  input  logic                         rst_n,

  // fetch
  input  logic                         instr_req_i,
  input  core_region_pkg::mem_req_t    instr_cmd_i,
  output logic                         instr_gnt_o,
  output logic                         instr_rvalid_o,
  output core_region_pkg::word_t       instr_rdata_o,

  // load/store
  input  logic                         lsu_req_i,
  input  core_region_pkg::mem_req_t    lsu_cmd_i,
  output logic                         lsu_gnt_o,
  output logic                         lsu_rvalid_o,
  output core_region_pkg::word_t       lsu_rdata_o,

  // loaders
  input  logic                         iload_req_i,
  input  core_region_pkg::loader_req_t iload_cmd_i,
  output core_region_pkg::word_t       iload_rdata_o,
  input  logic                         dload_req_i,
  input  core_region_pkg::loader_req_t dload_cmd_i,
  output core_region_pkg::word_t       dload_rdata_o,

  // external bus
  output logic                         ext_req_o,
  output core_region_pkg::mem_req_t    ext_cmd_o,
  input  logic                         ext_gnt_i,
  input  logic                         ext_rvalid_i,
  input  core_region_pkg::word_t       ext_rdata_i
);
  import core_region_pkg::*;

  logic     loc_req;
  mem_req_t loc_cmd;
  logic     loc_gnt;
  logic     loc_rvalid;
  word_t    loc_rdata;

  logic     instr_ram_en;
  ram_cmd_t instr_ram_cmd;
  word_t    instr_ram_rdata;

  logic     data_ram_en;
  ram_cmd_t data_ram_cmd;
  word_t    data_ram_rdata;

  lsu_demux data_demux
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_cmd_i    ( lsu_cmd_i    ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .loc_req_o    ( loc_req      ),
    .loc_cmd_o    ( loc_cmd      ),
    .loc_gnt_i    ( loc_gnt      ),
    .loc_rvalid_i ( loc_rvalid   ),
    .loc_rdata_i  ( loc_rdata    ),
    .ext_req_o    ( ext_req_o    ),
    .ext_cmd_o    ( ext_cmd_o    ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  )
  );

  // instruction side, fetch is read only
  ram_mux #(.ADDR_W(INSTR_ADDR_W), .CORE_WRITE(1'b0)) instr_ram_mux
  (
    .clk           ( clk             ),
    .rst_n         ( rst_n           ),
    .load_req_i    ( iload_req_i     ),
    .load_cmd_i    ( iload_cmd_i     ),
    .load_rdata_o  ( iload_rdata_o   ),
    .core_req_i    ( instr_req_i     ),
    .core_cmd_i    ( instr_cmd_i     ),
    .core_gnt_o    ( instr_gnt_o     ),
    .core_rvalid_o ( instr_rvalid_o  ),
    .core_rdata_o  ( instr_rdata_o   ),
    .ram_en_o      ( instr_ram_en    ),
    .ram_cmd_o     ( instr_ram_cmd   ),
    .ram_rdata_i   ( instr_ram_rdata )
  );

  sp_ram #(.ADDR_W(INSTR_ADDR_W)) instr_mem
  (
    .clk     ( clk             ),
    .en_i    ( instr_ram_en    ),
    .cmd_i   ( instr_ram_cmd   ),
    .rdata_o ( instr_ram_rdata )
  );

  ram_mux #(.ADDR_W(DATA_ADDR_W), .CORE_WRITE(1'b1)) data_ram_mux
  (
    .clk           ( clk            ),
    .rst_n         ( rst_n          ),
    .load_req_i    ( dload_req_i    ),
    .load_cmd_i    ( dload_cmd_i    ),
    .load_rdata_o  ( dload_rdata_o  ),
    .core_req_i    ( loc_req        ),
    .core_cmd_i    ( loc_cmd        ),
    .core_gnt_o    ( loc_gnt        ),
    .core_rvalid_o ( loc_rvalid     ),
    .core_rdata_o  ( loc_rdata      ),
    .ram_en_o      ( data_ram_en    ),
    .ram_cmd_o     ( data_ram_cmd   ),
    .ram_rdata_i   ( data_ram_rdata )
  );

  sp_ram #(.ADDR_W(DATA_ADDR_W)) data_mem
  (
    .clk     ( clk            ),
    .en_i    ( data_ram_en    ),
    .cmd_i   ( data_ram_cmd   ),
    .rdata_o ( data_ram_rdata )
  );

endmodule

//--- source/lsu_demux.sv
module lsu_demux
(
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      lsu_req_i,
  input  core_region_pkg::mem_req_t lsu_cmd_i,
  output logic                      lsu_gnt_o,
  output logic                      lsu_rvalid_o,
  output core_region_pkg::word_t    lsu_rdata_o,

  output logic                      loc_req_o,
  output core_region_pkg::mem_req_t loc_cmd_o,
  input  logic                      loc_gnt_i,
  input  logic                      loc_rvalid_i,
  input  core_region_pkg::word_t    loc_rdata_i,

  output logic                      ext_req_o,
  output core_region_pkg::mem_req_t ext_cmd_o,
  input  logic                      ext_gnt_i,
  input  logic                      ext_rvalid_i,
  input  core_region_pkg::word_t    ext_rdata_i
);
  import core_region_pkg::*;

  logic is_local;
  logic tgt_ext_q;

  assign is_local = (lsu_cmd_i.addr[LOCAL_TAG_HI:LOCAL_TAG_LO] == LOCAL_TAG);

  assign loc_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;
  assign loc_cmd_o = lsu_cmd_i;
  assign ext_cmd_o = lsu_cmd_i;

  assign lsu_gnt_o = (loc_req_o & loc_gnt_i) | (ext_req_o & ext_gnt_i);

  // where the next response comes from
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      tgt_ext_q <= 1'b0;
    end
    else if (lsu_req_i && lsu_gnt_o)
    begin
      tgt_ext_q <= ~is_local;
    end
  end

  always_comb
  begin
    lsu_rvalid_o = 1'b0;
    lsu_rdata_o  = '0;
    if (tgt_ext_q)
    begin
      lsu_rvalid_o = ext_rvalid_i;
      lsu_rdata_o  = ext_rvalid_i ? ext_rdata_i : '0;
    end
    else
    begin
      lsu_rvalid_o = loc_rvalid_i;
      lsu_rdata_o  = loc_rvalid_i ? loc_rdata_i : '0;
    end
  end

endmodule

//--- source/ram_mux.sv
module ram_mux
#(
  parameter int ADDR_W     = 8,
  parameter bit CORE_WRITE = 1'b1
)
(
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         load_req_i,
  input  core_region_pkg::loader_req_t load_cmd_i,
  output core_region_pkg::word_t       load_rdata_o,

  input  logic                         core_req_i,
  input  core_region_pkg::mem_req_t    core_cmd_i,
  output logic                         core_gnt_o,
  output logic                         core_rvalid_o,
  output core_region_pkg::word_t       core_rdata_o,

  output logic                         ram_en_o,
  output core_region_pkg::ram_cmd_t    ram_cmd_o,
  input  core_region_pkg::word_t       ram_rdata_i
);
  import core_region_pkg::*;

  ram_cmd_t core_ram_cmd;

  // loader always wins
  assign core_gnt_o = core_req_i & ~load_req_i;
  assign ram_en_o   = load_req_i | core_req_i;

  // byte address to word index
  always_comb
  begin
    core_ram_cmd                  = '0;
    core_ram_cmd.addr[ADDR_W-1:0] = core_cmd_i.addr[ADDR_W+1:2];
    // fetch port must never write
    core_ram_cmd.we               = CORE_WRITE ? core_cmd_i.we : 1'b0;
    core_ram_cmd.be               = core_cmd_i.be;
    core_ram_cmd.wdata            = core_cmd_i.wdata;
  end

  always_comb
  begin
    if (load_req_i)
    begin
      ram_cmd_o.addr  = load_cmd_i.addr;
      ram_cmd_o.we    = load_cmd_i.we;
      ram_cmd_o.be    = load_cmd_i.be;
      ram_cmd_o.wdata = load_cmd_i.wdata;
    end
    else
    begin
      ram_cmd_o = core_ram_cmd;
    end
  end

  // response one cycle after the core grant
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      core_rvalid_o <= 1'b0;
    end
    else
    begin
      core_rvalid_o <= core_gnt_o;
    end
  end

  // only one port used the RAM last cycle
  assign load_rdata_o = ram_rdata_i;
  assign core_rdata_o = ram_rdata_i;

endmodule

//--- source/sp_ram.sv
module sp_ram
#(
  parameter int ADDR_W = 8
)
(
  input  logic                      clk,
  input  logic                      en_i,
  input  core_region_pkg::ram_cmd_t cmd_i,
  output core_region_pkg::word_t    rdata_o
);
  import core_region_pkg::*;

  word_t             mem [0:2**ADDR_W-1];
  logic [ADDR_W-1:0] addr;

  assign addr = cmd_i.addr[ADDR_W-1:0];

  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (cmd_i.we)
      begin
        for (int b = 0; b < BE_W; b++)
        begin
          if (cmd_i.be[b])
          begin
            mem[addr][8*b +: 8] <= cmd_i.wdata[8*b +: 8];
          end
        end
        // writes answer with zero
        rdata_o <= '0;
      end
      else
      begin
        rdata_o <= mem[addr];
      end
    end
  end

endmodule

//--- source/core_region_pkg.sv
package core_region_pkg;

  // widths
  localparam int WORD_W       = 32;
  localparam int BE_W         = 4;
  localparam int WORD_IDX_W   = 16;
  localparam int INSTR_ADDR_W = 9;
  localparam int DATA_ADDR_W  = 8;

  // region tag in the upper byte address bits
  localparam int LOCAL_TAG_HI = 31;
  localparam int LOCAL_TAG_LO = 20;
  localparam logic [LOCAL_TAG_HI-LOCAL_TAG_LO:0] LOCAL_TAG = 12'h001;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [BE_W-1:0]       be_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  // core side, byte addressed
  typedef struct packed {
    word_t addr;
    logic  we;
    be_t   be;
    word_t wdata;
  } mem_req_t;

  // loader side, word indexed
  typedef struct packed {
    word_idx_t addr;
    logic      we;
    be_t       be;
    word_t     wdata;
  } loader_req_t;

  // what the RAM sees after arbitration
  typedef struct packed {
    word_idx_t addr;
    logic      we;
    be_t       be;
    word_t     wdata;
  } ram_cmd_t;

endpackage
